/* int_core_top.f */
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
src/instr_decode.sv
regread/reg_file.sv
regread/reg_read_stage.sv
src/alu_execute.sv
src/int_core_top.sv
verif/int_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the int_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f int_core_top.f --top-module int_core_tb -Mdir obj_dir -o int_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/int_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Verification passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* verif/int_core_tb.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module int_core_tb
    import pipe_pkg::*;
();

    // Instructions per test group sizing the run limit
    localparam int N_SEED     = 14;
    localparam int N_IMM      = 4;
    localparam int N_RAND     = 40;
    localparam int N_CHAIN    = 5;
    localparam int N_X0       = 6;
    localparam int N_DOUBLE   = 3;
    localparam int N_INSTR    = N_SEED + N_IMM + N_RAND + N_CHAIN + N_X0 + N_DOUBLE;
    localparam int MAX_CYCLES = 4 * N_INSTR + 100;

    logic             clk_i;
    logic             rstn_i;
    logic [`XLEN-1:0] instr_i;
    logic             instr_valid_i;
    logic             stall_o;
    wb_t              wb_o;

    logic [`XLEN-1:0] ref_regs [`NREGS];  // Architectural state in program order
    wb_t              exp_q [$];
    wb_t              exp_head;
    logic             head_avail;
    logic             idle_chk;
    logic [15:0]      lfsr_state;
    int               n_writes;
    int               wb_count;
    int               stall_cycles;
    int               cycles;
    int               err_value;
    int               err_other;

    int_core_top int_core_top_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .stall_o       (stall_o),
        .wb_o          (wb_o)
    );

    always #4 clk_i = ~clk_i;

    // ########################################
    // Scoreboard and run limit
    // ########################################

    always @(posedge clk_i) begin
        if (rstn_i && wb_o.valid) begin
            wb_count <= wb_count + 1;
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());  // Entry matched in the cycle just ended
            end
        end
        if (stall_o) begin
            stall_cycles <= stall_cycles + 1;
        end
        head_avail <= (exp_q.size() != 0);
        if (exp_q.size() != 0) begin
            exp_head <= exp_q[0];
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    wb_expected: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_o.valid |-> head_avail)
        else begin
            err_other++;
            $display("Writeback to x%0d arrived with no instruction outstanding",
                     $sampled(wb_o.rd));
        end

    wb_value: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (wb_o.valid && head_avail) |-> (wb_o.rd == exp_head.rd && wb_o.data == exp_head.data))
        else begin
            err_value++;
            $display("FAIL %0t: writeback x%0d = %h, expected x%0d = %h", $time,
                     $sampled(wb_o.rd), $sampled(wb_o.data),
                     $sampled(exp_head.rd), $sampled(exp_head.data));
        end

    no_x0_wb: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_o.valid |-> (wb_o.rd != 5'd0))
        else begin
            err_other++;
            $display("A writeback targeted register x0");
        end

    quiet_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        idle_chk |-> (!stall_o && !wb_o.valid))
        else begin
            err_other++;
            $display("Stall or writeback seen while idle after reset");
        end

    // ########################################
    // Stimulus helpers
    // ########################################

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Holds the instruction until decode can take it and records the expected writeback
    task automatic present_instr(input logic [31:0] instr, input logic writes,
                                 input logic [4:0] rd, input logic [31:0] data);
        wb_t e;
        @(negedge clk_i);
        instr_i       = instr;
        instr_valid_i = 1'b1;
        while (stall_o) begin
            @(negedge clk_i);
        end
        if (writes) begin
            e       = '0;
            e.valid = 1'b1;
            e.rd    = rd;
            e.data  = data;
            exp_q.push_back(e);
            ref_regs[rd] = data;
            n_writes++;
        end
    endtask

    task automatic run_rtype(input int kind, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [2:0]  f3;
        logic [6:0]  f7;
        a = ref_regs[rs1];
        b = ref_regs[rs2];
        case (kind)
            0: res = a + b;
            1: res = a - b;
            2: res = a & b;
            3: res = a | b;
            4: res = a ^ b;
            default: res = {31'b0, $signed(a) < $signed(b)};
        endcase
        case (kind)
            0, 1: f3 = 3'b000;
            2: f3 = 3'b111;
            3: f3 = 3'b110;
            4: f3 = 3'b100;
            default: f3 = 3'b010;
        endcase
        f7 = (kind == 1) ? 7'b0100000 : 7'b0000000;
        present_instr({f7, rs2, rs1, f3, rd, 7'b0110011}, rd != 5'd0, rd, res);
    endtask

    task automatic run_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] res;
        res = ref_regs[rs1] + {{20{imm[11]}}, imm};
        present_instr({imm, rs1, 3'b000, rd, 7'b0010011}, rd != 5'd0, rd, res);
    endtask

    task automatic run_lui(input logic [4:0] rd, input logic [19:0] imm);
        present_instr({imm, rd, 7'b0110111}, rd != 5'd0, rd, {imm, 12'b0});
    endtask

    // ########################################
    // Test sequence
    // ########################################

    initial begin
        logic [31:0] v;
        logic [31:0] k;
        logic [31:0] d;
        logic [31:0] s1;
        logic [31:0] s2;
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        idle_chk      = 1'b0;
        head_avail    = 1'b0;
        exp_head      = '0;
        lfsr_state    = 16'd88;
        n_writes      = 0;
        wb_count      = 0;
        stall_cycles  = 0;
        cycles        = 0;
        err_value     = 0;
        err_other     = 0;
        for (int r = 0; r < `NREGS; r++) begin
            ref_regs[r] = '0;
        end
        repeat (5) @(negedge clk_i);
        rstn_i   = 1'b1;
        idle_chk = 1'b1;
        repeat (6) @(negedge clk_i);
        idle_chk = 1'b0;

        for (logic [4:0] r = 5'd1; r < 5'd8; r++) begin  // Random contents for x1 to x7
            take_bits(20, v);
            run_lui(r, v[19:0]);
            take_bits(12, v);
            run_addi(r, r, v[11:0]);
        end

        run_addi(5'd12, 5'd1, 12'hFFB);
        run_addi(5'd13, 5'd0, 12'h800);
        run_lui(5'd14, 20'hABCDE);
        run_addi(5'd15, 5'd14, 12'hFFF);

        for (int i = 0; i < N_RAND; i++) begin
            take_bits(8, k);
            take_bits(3, d);
            take_bits(3, s1);
            take_bits(3, s2);
            run_rtype(int'(k % 32'd6), d[4:0], s1[4:0], s2[4:0]);
        end

        run_addi(5'd10, 5'd0, 12'd3);  // Each one needs the result before it
        run_rtype(0, 5'd10, 5'd10, 5'd10);
        run_rtype(1, 5'd11, 5'd10, 5'd12);
        run_rtype(5, 5'd11, 5'd11, 5'd10);
        run_addi(5'd11, 5'd11, 12'h7FF);

        run_addi(5'd0, 5'd1, 12'd77);
        present_instr(32'hFFFF_FFFF, 1'b0, 5'd0, '0);
        present_instr({7'b0, 5'd2, 5'd3, 3'b001, 5'd9, 7'b0110011}, 1'b0, 5'd0, '0);  // SLL
        present_instr({12'h0FF, 5'd3, 3'b111, 5'd9, 7'b0010011}, 1'b0, 5'd0, '0);      // ANDI
        run_rtype(0, 5'd7, 5'd0, 5'd0);
        run_rtype(3, 5'd8, 5'd9, 5'd0);

        run_addi(5'd20, 5'd0, 12'd111);
        run_addi(5'd20, 5'd0, 12'd222);
        run_rtype(0, 5'd21, 5'd20, 5'd0);

        @(negedge clk_i);
        instr_valid_i = 1'b0;
        while (wb_count < n_writes) begin
            @(posedge clk_i);
        end
        repeat (8) @(posedge clk_i);  // Room for any stray writeback

        stall_seen: assert (stall_cycles > 0)
            else begin
                err_other++;
                $display("Dependent instructions never raised stall");
            end
        count_match: assert (wb_count == n_writes)
            else begin
                err_other++;
                $display("Got %0d writebacks for %0d writing instructions", wb_count, n_writes);
            end

        $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* src/int_core_top.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module int_core_top
    import pipe_pkg::*;
(
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic [`XLEN-1:0] instr_i,
    input  logic             instr_valid_i,
    output logic             stall_o,
    output wb_t              wb_o
);

    dec_uop_t dec_uop;
    iss_uop_t iss_uop;
    wb_t      wb;
    logic     stall;

    instr_decode instr_decode_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .hold_i        (stall),
        .uop_o         (dec_uop)
    );

    reg_read_stage reg_read_stage_inst (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .dec_uop_i (dec_uop),
        .wb_i      (wb),        // Writeback loops back into the register file
        .stall_o   (stall),
        .iss_uop_o (iss_uop)
    );

    alu_execute alu_execute_inst (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .uop_i  (iss_uop),
        .wb_o   (wb)
    );

    assign stall_o = stall;
    assign wb_o    = wb;

endmodule

/* src/alu_execute.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module alu_execute
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  iss_uop_t uop_i,
    output wb_t      wb_o
);

    logic [`XLEN-1:0] result;
    logic             less;
    wb_t              wb_q;

    assign less = $signed(uop_i.a) < $signed(uop_i.b);

    always_comb begin
        case (uop_i.alu_op)
            ALU_ADD:    result = uop_i.a + uop_i.b;
            ALU_SUB:    result = uop_i.a - uop_i.b;
            ALU_AND:    result = uop_i.a & uop_i.b;
            ALU_OR:     result = uop_i.a | uop_i.b;
            ALU_XOR:    result = uop_i.a ^ uop_i.b;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, less};
            ALU_PASS_B: result = uop_i.b;
            default:    result = '0;
        endcase
    end

    // ########################################
    // Writeback register
    // ########################################

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q.valid <= uop_i.valid && uop_i.rd_en;  // No writeback for x0
        end
    end

    always_ff @(posedge clk_i) begin
        wb_q.rd   <= uop_i.rd;
        wb_q.tag  <= uop_i.tag;
        wb_q.data <= result;
    end

    assign wb_o = wb_q;

endmodule

/* regread/reg_read_stage.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module reg_read_stage
    import pipe_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  dec_uop_t dec_uop_i,
    input  wb_t      wb_i,
    output logic     stall_o,
    output iss_uop_t iss_uop_o
);

    logic [`XLEN-1:0]  rs1_data;
    logic [`XLEN-1:0]  rs2_data;
    logic              rs1_ready;
    logic              rs2_ready;
    logic              stall;
    logic              rsv_en;
    logic [`TAG_W-1:0] tag_q;
    iss_uop_t          iss_d;
    iss_uop_t          iss_q;

    reg_file reg_file_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .rd_addr1_i  (dec_uop_i.rs1),
        .rd_addr2_i  (dec_uop_i.rs2),
        .rd_data1_o  (rs1_data),
        .rd_data2_o  (rs2_data),
        .rd_ready1_o (rs1_ready),
        .rd_ready2_o (rs2_ready),
        .rsv_en_i    (rsv_en),
        .rsv_addr_i  (dec_uop_i.rd),
        .rsv_tag_i   (tag_q),
        .wb_i        (wb_i)
    );

    // Hold decode while any enabled source still waits on a writeback
    assign stall = dec_uop_i.valid
                && ((dec_uop_i.rs1_en && !rs1_ready) || (dec_uop_i.rs2_en && !rs2_ready));

    assign rsv_en = dec_uop_i.valid && dec_uop_i.rd_en && !stall;

    always_comb begin
        iss_d.valid  = dec_uop_i.valid && !stall;  // Bubble while stalled
        iss_d.alu_op = dec_uop_i.alu_op;
        iss_d.a      = rs1_data;
        iss_d.b      = dec_uop_i.use_imm ? dec_uop_i.imm : rs2_data;
        iss_d.rd     = dec_uop_i.rd;
        iss_d.rd_en  = dec_uop_i.rd_en;
        iss_d.tag    = tag_q;
    end

    // ########################################
    // Tag counter and issue register
    // ########################################

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            tag_q <= '0;
            iss_q <= '0;
        end else begin
            if (rsv_en) begin
                tag_q <= tag_q + 1'b1;
            end
            iss_q <= iss_d;
        end
    end

    assign stall_o   = stall;
    assign iss_uop_o = iss_q;

endmodule

/* regread/reg_file.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module reg_file
    import pipe_pkg::*;
(
    input  logic               clk_i,
    input  logic               rstn_i,

    input  logic [`REG_AW-1:0] rd_addr1_i,
    input  logic [`REG_AW-1:0] rd_addr2_i,
    output logic [`XLEN-1:0]   rd_data1_o,
    output logic [`XLEN-1:0]   rd_data2_o,
    output logic               rd_ready1_o,
    output logic               rd_ready2_o,

    input  logic               rsv_en_i,
    input  logic [`REG_AW-1:0] rsv_addr_i,
    input  logic [`TAG_W-1:0]  rsv_tag_i,

    input  wb_t                wb_i
);

    logic [`XLEN-1:0]  data_q [`NREGS];
    logic [`TAG_W-1:0] tag_q  [`NREGS];
    logic [`NREGS-1:0] pend_q;

    logic wb_wr;
    logic wb_match;
    logic rsv_same;
    logic fwd1;
    logic fwd2;

    assign wb_wr    = wb_i.valid && (wb_i.rd != '0);
    assign wb_match = wb_wr && (tag_q[wb_i.rd] == wb_i.tag);  // Latest reservation only
    assign rsv_same = rsv_en_i && (rsv_addr_i == wb_i.rd);

    // ########################################
    // Read ports with writeback forwarding
    // ########################################

    assign fwd1 = wb_wr && (wb_i.rd == rd_addr1_i);
    assign fwd2 = wb_wr && (wb_i.rd == rd_addr2_i);

    assign rd_data1_o  = (rd_addr1_i == '0) ? '0 : (fwd1 ? wb_i.data : data_q[rd_addr1_i]);
    assign rd_data2_o  = (rd_addr2_i == '0) ? '0 : (fwd2 ? wb_i.data : data_q[rd_addr2_i]);

    assign rd_ready1_o = (rd_addr1_i == '0) || !pend_q[rd_addr1_i]
                      || (fwd1 && (tag_q[rd_addr1_i] == wb_i.tag));
    assign rd_ready2_o = (rd_addr2_i == '0) || !pend_q[rd_addr2_i]
                      || (fwd2 && (tag_q[rd_addr2_i] == wb_i.tag));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `NREGS; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end
            pend_q <= '0;
        end else begin
            if (wb_wr) begin
                data_q[wb_i.rd] <= wb_i.data;
                if (wb_match && !rsv_same) begin
                    pend_q[wb_i.rd] <= 1'b0;
                end
            end
            if (rsv_en_i && (rsv_addr_i != '0)) begin  // x0 never pends
                pend_q[rsv_addr_i] <= 1'b1;
                tag_q[rsv_addr_i]  <= rsv_tag_i;
            end
        end
    end

endmodule

/* src/instr_decode.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module instr_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic [`XLEN-1:0] instr_i,
    input  logic             instr_valid_i,
    input  logic             hold_i,
    output dec_uop_t         uop_o
);

    r_instr_t ins;
    dec_uop_t uop_d;
    dec_uop_t uop_q;
    logic     legal;

    assign ins = instr_i;

    always_comb begin
        legal         = 1'b0;
        uop_d         = '0;
        uop_d.alu_op  = ALU_ADD;
        uop_d.rs1     = ins.rs1;
        uop_d.rs2     = ins.rs2;
        uop_d.rd      = ins.rd;

        case (ins.opcode)
            OP_REG: begin
                uop_d.rs1_en = 1'b1;
                uop_d.rs2_en = 1'b1;
                legal        = 1'b1;
                if (ins.funct7 == F7_SUB && ins.funct3 == F3_ADD_SUB) begin
                    uop_d.alu_op = ALU_SUB;
                end else if (ins.funct7 == F7_BASE) begin
                    case (ins.funct3)
                        F3_ADD_SUB: uop_d.alu_op = ALU_ADD;
                        F3_SLT:     uop_d.alu_op = ALU_SLT;
                        F3_XOR:     uop_d.alu_op = ALU_XOR;
                        F3_OR:      uop_d.alu_op = ALU_OR;
                        F3_AND:     uop_d.alu_op = ALU_AND;
                        default:    legal = 1'b0;
                    endcase
                end else begin
                    legal = 1'b0;
                end
            end
            OP_IMM: begin  // ADDI only
                legal         = (ins.funct3 == F3_ADD_SUB);
                uop_d.rs1_en  = 1'b1;
                uop_d.use_imm = 1'b1;
                uop_d.imm     = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
            end
            OP_LUI: begin
                legal         = 1'b1;
                uop_d.alu_op  = ALU_PASS_B;
                uop_d.use_imm = 1'b1;
                uop_d.imm     = {instr_i[31:12], 12'b0};
            end
            default: legal = 1'b0;
        endcase

        uop_d.valid = instr_valid_i && legal;
        uop_d.rd_en = legal && (ins.rd != '0);
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            uop_q <= '0;
        end else if (!hold_i) begin
            uop_q <= uop_d;
        end
    end

    assign uop_o = uop_q;

endmodule

/* common/pipe_pkg.sv */
`include "core_cfg.svh"

package pipe_pkg;

    import isa_pkg::*;

    // ########################################
    // Decode to register read
    // ########################################

    typedef struct packed {
        logic               valid;
        alu_op_e            alu_op;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic               rs1_en;
        logic               rs2_en;
        logic [`REG_AW-1:0] rd;
        logic               rd_en;    // Low for x0
        logic               use_imm;
        logic [`XLEN-1:0]   imm;      // Sign-extended or upper immediate
    } dec_uop_t;

    // ########################################
    // Register read to execute
    // ########################################

    typedef struct packed {
        logic               valid;
        alu_op_e            alu_op;
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;        // Immediate already selected
        logic [`REG_AW-1:0] rd;
        logic               rd_en;
        logic [`TAG_W-1:0]  tag;
    } iss_uop_t;

    // Writeback back into the register file
    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic [`TAG_W-1:0]  tag;
        logic [`XLEN-1:0]   data;
    } wb_t;

endpackage

/* common/isa_pkg.sv */
`include "core_cfg.svh"

package isa_pkg;

    // Base 32-bit instruction laid out in R-type order
    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } r_instr_t;

    // ########################################
    // Opcodes and function codes
    // ########################################

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000; // Also ADDI
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // LUI
    } alu_op_e;

endpackage

/* common/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ########################################
// Datapath sizing
// ########################################

// Data word width
`define XLEN    32

// Architectural register count and its address width
`define NREGS   32
`define REG_AW  5

// Reservation tag width for up to 8 tags in flight
`define TAG_W   3

`endif
